// ==== include/alu_cfg.svh ====
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

// datapath width
`define XLEN 32

// reorder-buffer tag width
`define TAG_W 4

`define REG_W 5 // architectural register index

`endif

// ==== source/ooo_pkg.sv ====
`include "alu_cfg.svh"

package ooo_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_LT,
    ALU_LTU,
    ALU_EQ,
    ALU_NE,
    ALU_GE,
    ALU_GEU
  } alu_op_e;

  // major opcodes
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;
  localparam logic [6:0] OPC_CUSTOM0 = 7'b0001011; // compare group

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra, srai

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // custom-0 compares follow the branch funct3 layout
  localparam logic [2:0] F3_EQ  = 3'b000;
  localparam logic [2:0] F3_NE  = 3'b001;
  localparam logic [2:0] F3_GE  = 3'b101;
  localparam logic [2:0] F3_GEU = 3'b111;

  typedef struct packed {
    logic [6:0]        funct7;
    logic [`REG_W-1:0] rs2;
    logic [`REG_W-1:0] rs1;
    logic [2:0]        funct3;
    logic [`REG_W-1:0] rd;
    logic [6:0]        opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0]       imm;
    logic [`REG_W-1:0] rs1;
    logic [2:0]        funct3;
    logic [`REG_W-1:0] rd;
    logic [6:0]        opcode;
  } i_type_t;

  // one instruction word, two views of the upper bits
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_u;

  typedef struct packed {
    logic              valid;
    instr_u            instr;
    logic [`XLEN-1:0]  rs1_val;
    logic [`XLEN-1:0]  rs2_val;
    logic [`TAG_W-1:0] tag;
  } issue_t;

  typedef struct packed {
    logic              valid;
    alu_op_e           operation;
    logic [`XLEN-1:0]  operand_a;
    logic [`XLEN-1:0]  operand_b;
    logic [`REG_W-1:0] rd;
    logic [`TAG_W-1:0] tag;
    logic              illegal;
  } fu_data_t;

  typedef struct packed {
    logic              valid;
    logic [`TAG_W-1:0] tag;
    logic [`REG_W-1:0] rd;
    logic [`XLEN-1:0]  value;
    logic              illegal;
  } result_t;

endpackage

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
  import ooo_pkg::*;
(
  input  fu_data_t    fu_data,
  output logic [31:0] alu_result
);

  logic [31:0] opa;
  logic [31:0] opb;
  logic [32:0] add_a;
  logic [32:0] add_b;
  logic [33:0] sum;
  logic        nz;
  logic        lt;
  logic [4:0]  shamt;
  logic [32:0] sh_in;
  logic [32:0] sh_out;
  logic [31:0] logic_res;

  function automatic logic [31:0] reverse32(input logic [31:0] x);
    logic [31:0] y;
    for (int i = 0; i < 32; i++) begin
      y[i] = x[31-i];
    end
    return y;
  endfunction

  assign opa = fu_data.operand_a;
  assign opb = fu_data.operand_b;

  // bit 0 carries the +1 of a - b, the sum sits in [32:1]
  assign add_a = {opa, 1'b1};
  always_comb begin
    case (fu_data.operation)
      ALU_SUB, ALU_LT, ALU_LTU, ALU_EQ, ALU_NE, ALU_GE, ALU_GEU: add_b = {~opb, 1'b1};
      default: add_b = {opb, 1'b0};
    endcase
  end
  assign sum = {1'b0, add_a} + {1'b0, add_b};
  assign nz  = |sum[32:1];

  always_comb begin
    case (fu_data.operation)
      ALU_LT, ALU_GE: lt = (opa[31] == opb[31]) ? sum[32] : opa[31]; // signed
      default:        lt = ~sum[33];                                  // no carry out, a < b
    endcase
  end

  // one right shifter, sll runs reversed through it
  assign shamt = opb[4:0];
  always_comb begin
    case (fu_data.operation)
      ALU_SLL: sh_in = {1'b0, reverse32(opa)};
      ALU_SRA: sh_in = {opa[31], opa};
      default: sh_in = {1'b0, opa};
    endcase
  end
  assign sh_out = (sh_in >> shamt) | ({33{sh_in[32]}} << (6'd32 - shamt)); // fill from the top

  always_comb begin
    case (fu_data.operation)
      ALU_OR:  logic_res = opa | opb;
      ALU_XOR: logic_res = opa ^ opb;
      default: logic_res = opa & opb;
    endcase
  end

  always_comb begin
    case (fu_data.operation)
      ALU_ADD, ALU_SUB:         alu_result = sum[32:1];
      ALU_EQ:                   alu_result = {31'b0, ~nz};
      ALU_NE:                   alu_result = {31'b0, nz};
      ALU_LT, ALU_LTU:          alu_result = {31'b0, lt};
      ALU_GE, ALU_GEU:          alu_result = {31'b0, ~lt};
      ALU_SLL:                  alu_result = reverse32(sh_out[31:0]);
      ALU_SRL, ALU_SRA:         alu_result = sh_out[31:0];
      ALU_AND, ALU_OR, ALU_XOR: alu_result = logic_res;
      default:                  alu_result = sum[32:1];
    endcase
  end

endmodule

`default_nettype wire

// ==== source/op_decode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "alu_cfg.svh"

module op_decode
  import ooo_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  issue_t   issue,
  input  result_t  bypass_exec,
  input  result_t  bypass_wb,
  output fu_data_t fu_data
);

  alu_op_e          op;
  logic             illegal;
  logic             use_imm;
  logic             use_shamt;
  logic [`XLEN-1:0] imm_sext;
  logic [`XLEN-1:0] shamt_ext;
  logic [`XLEN-1:0] src_a;
  logic [`XLEN-1:0] src_b;
  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;

  // exec result is newer than wb, x0 is never forwarded
  function automatic logic [`XLEN-1:0] fwd_val(
    input logic [`REG_W-1:0] rs,
    input logic [`XLEN-1:0]  reg_val,
    input result_t           byp_new,
    input result_t           byp_old
  );
    logic [`XLEN-1:0] val;
    if (byp_new.valid && !byp_new.illegal && byp_new.rd == rs && rs != '0) begin
      val = byp_new.value;
    end else if (byp_old.valid && !byp_old.illegal && byp_old.rd == rs && rs != '0) begin
      val = byp_old.value;
    end else begin
      val = reg_val;
    end
    return val;
  endfunction

  assign imm_sext  = {{(`XLEN-12){issue.instr.i.imm[11]}}, issue.instr.i.imm};
  assign shamt_ext = {{(`XLEN-5){1'b0}}, issue.instr.i.imm[4:0]};

  always_comb begin
    op        = ALU_ADD;
    illegal   = 1'b0;
    use_imm   = 1'b0;
    use_shamt = 1'b0;
    case (issue.instr.r.opcode)
      OPC_OP: begin
        case ({issue.instr.r.funct7, issue.instr.r.funct3})
          {F7_BASE, F3_ADD}:  op = ALU_ADD;
          {F7_ALT,  F3_ADD}:  op = ALU_SUB;
          {F7_BASE, F3_SLL}:  op = ALU_SLL;
          {F7_BASE, F3_SLT}:  op = ALU_LT;
          {F7_BASE, F3_SLTU}: op = ALU_LTU;
          {F7_BASE, F3_XOR}:  op = ALU_XOR;
          {F7_BASE, F3_SR}:   op = ALU_SRL;
          {F7_ALT,  F3_SR}:   op = ALU_SRA;
          {F7_BASE, F3_OR}:   op = ALU_OR;
          {F7_BASE, F3_AND}:  op = ALU_AND;
          default:            illegal = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        use_imm = 1'b1;
        case (issue.instr.i.funct3)
          F3_ADD:  op = ALU_ADD;
          F3_SLT:  op = ALU_LT;
          F3_SLTU: op = ALU_LTU;
          F3_XOR:  op = ALU_XOR;
          F3_OR:   op = ALU_OR;
          F3_AND:  op = ALU_AND;
          F3_SLL: begin
            use_shamt = 1'b1;
            op        = ALU_SLL;
            illegal   = issue.instr.i.imm[11:5] != F7_BASE;
          end
          default: begin // F3_SR, srli or srai by imm[11:5]
            use_shamt = 1'b1;
            if (issue.instr.i.imm[11:5] == F7_BASE) op = ALU_SRL;
            else if (issue.instr.i.imm[11:5] == F7_ALT) op = ALU_SRA;
            else illegal = 1'b1;
          end
        endcase
      end
      OPC_CUSTOM0: begin
        case ({issue.instr.r.funct7, issue.instr.r.funct3})
          {F7_BASE, F3_EQ}:  op = ALU_EQ;
          {F7_BASE, F3_NE}:  op = ALU_NE;
          {F7_BASE, F3_GE}:  op = ALU_GE;
          {F7_BASE, F3_GEU}: op = ALU_GEU;
          default:           illegal = 1'b1;
        endcase
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) op = ALU_ADD; // 0 + 0 gives the zero value
  end

  assign src_a = fwd_val(issue.instr.r.rs1, issue.rs1_val, bypass_exec, bypass_wb);
  assign src_b = fwd_val(issue.instr.r.rs2, issue.rs2_val, bypass_exec, bypass_wb);

  always_comb begin
    op_a = src_a;
    if (use_shamt) op_b = shamt_ext;
    else if (use_imm) op_b = imm_sext;
    else op_b = src_b; // R-type only
    if (illegal) begin
      op_a = '0;
      op_b = '0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      fu_data <= '0;
    end else begin
      fu_data.valid     <= issue.valid;
      fu_data.operation <= op;
      fu_data.operand_a <= op_a;
      fu_data.operand_b <= op_b;
      fu_data.rd        <= issue.instr.r.rd;
      fu_data.tag       <= issue.tag;
      fu_data.illegal   <= illegal;
    end
  end

endmodule

`default_nettype wire

// ==== source/exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_stage
  import ooo_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  fu_data_t fu_data,
  output result_t  bypass_exec,
  output result_t  result
);

  logic [31:0] alu_result;

  alu i_alu (
    .fu_data    (fu_data),
    .alu_result (alu_result)
  );

  // same-cycle result, fed back to decode ahead of the register
  always_comb begin
    bypass_exec.valid   = fu_data.valid;
    bypass_exec.tag     = fu_data.tag;
    bypass_exec.rd      = fu_data.rd;
    bypass_exec.value   = alu_result; // zero for illegal records
    bypass_exec.illegal = fu_data.illegal;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result <= '0;
    end else begin
      result <= bypass_exec;
    end
  end

endmodule

`default_nettype wire

// ==== source/int_exec_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_exec_lane
  import ooo_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  issue_t  issue,
  output result_t result
);

  fu_data_t fu_data;
  result_t  bypass_exec;

  op_decode i_op_decode (
    .clk         (clk),
    .arst_n      (arst_n),
    .issue       (issue),
    .bypass_exec (bypass_exec),
    .bypass_wb   (result),    // registered lane output doubles as older bypass
    .fu_data     (fu_data)
  );

  exec_stage i_exec_stage (
    .clk         (clk),
    .arst_n      (arst_n),
    .fu_data     (fu_data),
    .bypass_exec (bypass_exec),
    .result      (result)
  );

endmodule

`default_nettype wire

// ==== test/int_exec_lane_assertions.sv ====
`timescale 1ns/1ps

module int_exec_lane_assertions
  import ooo_pkg::*;
(
  input logic    clk,
  input logic    arst_n,
  input issue_t  issue,
  input result_t result
);

  int n_fail = 0;

  // first edge out of reset sees an empty pipeline
  assert property (@(posedge clk) $rose(arst_n) |-> !result.valid)
    else begin
      $error("result.valid high on the first edge after reset");
      n_fail++;
    end

  // fixed two-cycle latency with one result per issued instruction
  assert property (@(posedge clk) disable iff (!arst_n)
    result.valid == $past(issue.valid, 2))
    else begin
      $error("result.valid does not follow issue.valid by two cycles");
      n_fail++;
    end

  assert property (@(posedge clk) disable iff (!arst_n)
    (result.valid && result.illegal) |-> (result.value == '0))
    else begin
      $error("illegal result carries a nonzero value");
      n_fail++;
    end

endmodule

bind int_exec_lane int_exec_lane_assertions i_int_exec_lane_assertions (
  .clk    (clk),
  .arst_n (arst_n),
  .issue  (issue),
  .result (result)
);

// ==== test/tb_int_exec_lane.sv ====
`timescale 1ns/1ps
`include "alu_cfg.svh"

module tb_int_exec_lane
  import ooo_pkg::*;
();

  localparam int N_R       = 200;
  localparam int N_I       = 200;
  localparam int N_CMP     = 100;
  localparam int N_CHAIN   = 20;
  localparam int CHAIN_LEN = 8;
  localparam int N_ILL     = 40;
  localparam int N_TESTS   = 6;
  localparam int MAX_GAP   = 3;
  localparam int N_SEND    = N_R + N_I + 2 * N_CMP + 2 + N_CHAIN * CHAIN_LEN + 2 * N_ILL;
  // every send may be followed by MAX_GAP idle cycles and each test drains in a few more
  localparam int LIMIT     = N_SEND * (1 + MAX_GAP) + 6 * N_TESTS + 2 + 20;

  logic    clk;
  logic    arst_n;
  issue_t  issue;
  result_t result;

  logic [31:0]      lfsr = 32'hb106;
  logic [`XLEN-1:0] arch_rf [32]; // program-order state
  logic [`XLEN-1:0] dut_rf [32];  // written only as results leave the lane
  logic [2:0]       cmp_f3 [4] = '{3'd0, 3'd1, 3'd5, 3'd7}; // eq ne ge geu
  result_t          exp_q [$];
  logic [`TAG_W-1:0] tag = '0;
  int cycles = 0;
  int err_count = 0;
  int n_checks = 0;
  int n_tests = 0;
  int n_bad = 0;
  int err_mark = 0;
  int check_mark = 0;

  int_exec_lane i_int_exec_lane (
    .clk    (clk),
    .arst_n (arst_n),
    .issue  (issue),
    .result (result)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  initial begin
    wait (cycles >= LIMIT);
    $display("timeout after %0d cycles with %0d results outstanding", cycles, exp_q.size());
    $display("Some tests failed");
    $finish;
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'(rand_bits(5));
  endfunction

  function automatic int pick_gap();
    return int'(rand_bits(2));
  endfunction

  function automatic logic [31:0] r_type_word(input logic [4:0] rd, rs1, rs2);
    logic [2:0] f3;
    logic       alt;
    f3  = 3'(rand_bits(3));
    alt = 1'(rand_bits(1));
    if (f3 != 3'd0 && f3 != 3'd5) alt = 1'b0; // only sub and sra have an alternate
    return {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] imm_word(input logic [4:0] rd, rs1);
    logic [2:0]  f3;
    logic [11:0] imm;
    f3  = 3'(rand_bits(3));
    imm = 12'(rand_bits(12));
    if (f3 == 3'd1) imm[11:5] = 7'h00;
    if (f3 == 3'd5) imm[11:5] = imm[11] ? 7'h20 : 7'h00;
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  // returns {illegal, value}
  function automatic logic [32:0] model_exec(input logic [31:0] w, a, b);
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [31:0] imm;
    logic [31:0] r;
    logic        bad;
    f7  = w[31:25];
    f3  = w[14:12];
    imm = {{20{w[31]}}, w[31:20]};
    r   = '0;
    bad = 1'b0;
    if (w[6:0] == 7'h33) begin
      case ({f7, f3})
        {7'h00, 3'd0}: r = a + b;
        {7'h20, 3'd0}: r = a - b;
        {7'h00, 3'd1}: r = a << b[4:0];
        {7'h00, 3'd2}: r = {31'b0, $signed(a) < $signed(b)};
        {7'h00, 3'd3}: r = {31'b0, a < b};
        {7'h00, 3'd4}: r = a ^ b;
        {7'h00, 3'd5}: r = a >> b[4:0];
        {7'h20, 3'd5}: r = $signed(a) >>> b[4:0];
        {7'h00, 3'd6}: r = a | b;
        {7'h00, 3'd7}: r = a & b;
        default:       bad = 1'b1;
      endcase
    end else if (w[6:0] == 7'h13) begin
      case (f3)
        3'd0: r = a + imm;
        3'd2: r = {31'b0, $signed(a) < $signed(imm)};
        3'd3: r = {31'b0, a < imm};
        3'd4: r = a ^ imm;
        3'd6: r = a | imm;
        3'd7: r = a & imm;
        3'd1: if (f7 == 7'h00) r = a << w[24:20]; else bad = 1'b1;
        default: begin
          if (f7 == 7'h00) r = a >> w[24:20];
          else if (f7 == 7'h20) r = $signed(a) >>> w[24:20];
          else bad = 1'b1;
        end
      endcase
    end else if (w[6:0] == 7'h0b) begin
      case ({f7, f3})
        {7'h00, 3'd0}: r = {31'b0, a == b};
        {7'h00, 3'd1}: r = {31'b0, a != b};
        {7'h00, 3'd5}: r = {31'b0, $signed(a) >= $signed(b)};
        {7'h00, 3'd7}: r = {31'b0, a >= b};
        default:       bad = 1'b1;
      endcase
    end else begin
      bad = 1'b1;
    end
    if (bad) r = '0;
    return {bad, r};
  endfunction

  task automatic report_mismatch(input string sig, input logic [31:0] got, exp);
    $display("error %0t %s got %h expected %h", $time, sig, got, exp);
    err_count++;
  endtask

  task automatic check_result();
    result_t e;
    if (result.valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("result at %0t with no instruction outstanding", $time);
        err_count++;
      end else begin
        e = exp_q.pop_front();
        n_checks++;
        if (result.tag !== e.tag) report_mismatch("result.tag", result.tag, e.tag);
        if (result.rd !== e.rd) report_mismatch("result.rd", result.rd, e.rd);
        if (result.value !== e.value) report_mismatch("result.value", result.value, e.value);
        if (result.illegal !== e.illegal) begin
          report_mismatch("result.illegal", result.illegal, e.illegal);
        end
      end
      if (!result.illegal && result.rd != '0) dut_rf[result.rd] = result.value;
    end
  endtask

  task automatic next_cycle();
    @(negedge clk);
    check_result();
  endtask

  task automatic send(input logic [31:0] w, input int gap);
    logic [32:0]      m;
    result_t          e;
    logic [`XLEN-1:0] v1;
    logic [`XLEN-1:0] v2;
    // register state before the issue cycle, the result leaving now comes over the bypass
    v1 = dut_rf[w[19:15]];
    v2 = dut_rf[w[24:20]];
    next_cycle();
    issue.valid   = 1'b1;
    issue.instr   = w;
    issue.rs1_val = v1;
    issue.rs2_val = v2;
    issue.tag     = tag;
    m = model_exec(w, arch_rf[w[19:15]], arch_rf[w[24:20]]);
    e.valid   = 1'b1;
    e.tag     = tag;
    e.rd      = w[11:7];
    e.value   = m[31:0];
    e.illegal = m[32];
    exp_q.push_back(e);
    if (!e.illegal && e.rd != '0) arch_rf[e.rd] = e.value;
    tag++;
    repeat (gap) begin
      next_cycle();
      issue.valid = 1'b0;
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    while (exp_q.size() != 0) begin
      next_cycle();
      issue.valid = 1'b0;
    end
    repeat (2) begin // catch stray results
      next_cycle();
      issue.valid = 1'b0;
    end
    errs = err_count - err_mark;
    $display("test %0s finished, %0d checks, %0d errors", name, n_checks - check_mark, errs);
    n_tests++;
    if (errs != 0) n_bad++;
    err_mark   = err_count;
    check_mark = n_checks;
  endtask

  initial begin
    logic [31:0] w;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  prev1;
    logic [4:0]  prev2;
    issue  = '0;
    arst_n = 1'b0;
    arch_rf[0] = '0;
    for (int k = 1; k < 32; k++) arch_rf[k] = rand_bits(32);
    dut_rf = arch_rf;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    next_cycle();
    if (result.valid !== 1'b0) report_mismatch("result.valid", result.valid, 32'd0);
    end_test("reset");

    repeat (N_R) send(r_type_word(rand_reg(), rand_reg(), rand_reg()), pick_gap());
    end_test("op");

    repeat (N_I) send(imm_word(rand_reg(), rand_reg()), pick_gap());
    end_test("op_imm");

    send({12'd1, 5'd0, 3'd0, 5'd31, 7'h13}, 0);          // x31 = 1
    send({7'h00, 5'd31, 5'd31, 3'd1, 5'd31, 7'h13}, 0);  // x31 = sign bit only
    repeat (N_CMP) begin
      rd  = 5'(rand_bits(4)) + 5'd1; // leaves x30 and x31 alone
      rs1 = rand_reg();
      rs2 = rand_reg();
      case (rand_bits(2))
        0: rs2 = rs1;
        1: begin
          send({7'h00, 5'd31, rs1, 3'd4, 5'd30, 7'h33}, 0); // x30 = rs1 with sign flipped
          rs2 = 5'd30;
        end
        default: ;
      endcase
      send({7'h00, rs2, rs1, cmp_f3[rand_bits(2)], rd, 7'h0b}, pick_gap());
    end
    end_test("compare");

    repeat (N_CHAIN) begin
      prev1 = rand_reg();
      prev2 = rand_reg();
      for (int k = 0; k < CHAIN_LEN; k++) begin
        rd  = (rand_bits(3) == 0) ? 5'd0 : rand_reg();
        rs1 = rand_bits(1) ? prev1 : prev2;
        rs2 = rand_bits(1) ? prev1 : prev2;
        w   = rand_bits(1) ? r_type_word(rd, rs1, rs2) : imm_word(rd, rs1);
        send(w, (k == CHAIN_LEN - 1) ? pick_gap() : 0);
        prev2 = prev1;
        prev1 = rd;
      end
    end
    end_test("chain");

    repeat (N_ILL) begin
      w = rand_bits(32);
      case (rand_bits(2))
        0: w[6:0] = 7'h33;
        1: w[6:0] = 7'h13;
        2: w[6:0] = 7'h0b;
        default: ;
      endcase
      case (w[6:0]) // break the funct fields of known opcodes
        7'h33: w[31:25] = 7'h7f;
        7'h13: begin
          w[14:12] = 3'd1;
          w[31:25] = 7'h7f;
        end
        7'h0b: w[14:12] = 3'd2;
        default: ;
      endcase
      send(w, 0);
      send(r_type_word(rand_reg(), w[11:7], w[11:7]), pick_gap()); // reads the illegal rd
    end
    end_test("illegal");

    err_count += i_int_exec_lane.i_int_exec_lane_assertions.n_fail; // bound checker failures
    $display("%0d tests, %0d with errors, %0d results checked, %0d errors",
             n_tests, n_bad, n_checks, err_count);
    if (err_count == 0 && n_bad == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== int_exec_lane.f ====
+incdir+include
source/ooo_pkg.sv
source/alu.sv
source/op_decode.sv
source/exec_stage.sv
source/int_exec_lane.sv
test/int_exec_lane_assertions.sv
test/tb_int_exec_lane.sv
